// File: common/div_params.svh
`ifndef DIV_PARAMS_SVH
`define DIV_PARAMS_SVH

// ==============================
// Divide unit sizing
// ==============================

// Operand and result width
// The lane fixed-point datapath is built for 64 bits only
`define DIV_XLEN 64

// Number of Newton-Raphson lanes
`define DIV_LANES 4

// Request tag width
`define DIV_TAG_W 4

// One result slot per lane
`define DIV_QUEUE_DEPTH `DIV_LANES

`endif

// File: common/div_pkg.sv
`include "div_params.svh"

package div_pkg;

    typedef logic [`DIV_XLEN-1:0]  div_word_t;
    typedef logic [`DIV_TAG_W-1:0] div_tag_t;

    // Incoming divide request
    typedef struct packed {
        div_tag_t  tag;
        div_word_t a;
        div_word_t b;
        logic      do_rem;
    } div_req_t;

    // Held per lane while it works
    typedef struct packed {
        div_tag_t  tag;
        div_word_t a;
        logic      b_zero;
        logic      do_rem;
    } div_ctx_t;

    typedef struct packed {
        div_tag_t  tag;
        div_word_t result;
        logic      by_zero;
    } div_resp_t;

endpackage

// File: divider/recip_mult.sv
`timescale 1ns/100ps

// Fixed-point multiplier for the reciprocal lane
// Both operands carry 64 fraction bits and so does r
module recip_mult (
    input  logic         clk,
    input  logic [65:0]  a,
    input  logic [127:0] b,
    output logic [127:0] r
);

    logic [65:0]         a_q;
    logic [127:0]        b_q;
    logic signed [194:0] prod;

    // ==============================
    // Stage 1 operand capture
    // ==============================
    always_ff @(posedge clk) begin
        a_q <= a;
        b_q <= b;
    end

    // a is unsigned, b is two's complement
    // Lets the error term 1 - b*x go below zero
    assign prod = $signed({1'b0, a_q}) * $signed(b_q);

    // ==============================
    // Stage 2 product
    // ==============================
    always_ff @(posedge clk) begin
        // Drop the extra fraction bits
        r <= prod[191:64];
    end

endmodule

// File: divider/nr_divider.sv
`timescale 1ns/100ps

// One Newton-Raphson divide lane
// For a remainder request the result is quotient times divisor
module nr_divider (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  div_pkg::div_word_t a_in,
    input  div_pkg::div_word_t b_in,
    input  logic               do_rem,
    output logic               done,
    output div_pkg::div_word_t result
);
    import div_pkg::*;

    // Q.64 constants
    localparam logic [65:0]  SEED_SLOPE = 66'h1_e1e1_e1e1_e1e1_e1e1;   // 32/17
    localparam logic [127:0] SEED_BASE  = 128'h2_d2d2_d2d2_d2d2_d2d2;  // 48/17
    localparam logic [127:0] FIX_ONE    = 128'h1_0000_0000_0000_0000;

    // Step schedule, counter value at which each multiply is issued
    localparam logic [5:0] STEP_SEED     = 6'd2;
    localparam logic [5:0] STEP_DIVIDEND = 6'd26;
    localparam logic [5:0] STEP_REMUL    = 6'd28;
    localparam logic [5:0] DONE_QUOT     = 6'd28;
    localparam logic [5:0] DONE_REM      = 6'd30;

    logic [5:0]   counter;
    logic [5:0]   last_step;
    logic [5:0]   lead_pos;
    logic [5:0]   shift;
    logic [127:0] b_norm_in;
    logic [127:0] a_norm;
    logic [127:0] b_norm;
    div_word_t    b_orig;
    logic [65:0]  x;
    logic [127:0] x_next;
    logic [127:0] seed_x;
    logic [65:0]  mult_a;
    logic [127:0] mult_b;
    logic [127:0] mult_r;

    // Highest set bit wins
    function automatic logic [5:0] lead_one(input div_word_t v);
        logic [5:0] pos;
        pos = '0;
        for (int i = 0; i < $bits(div_word_t); i++) begin
            if (v[i]) begin
                pos = i[5:0];
            end
        end
        return pos;
    endfunction

    recip_mult recip_mult_inst (
        .clk (clk),
        .a   (mult_a),
        .b   (mult_b),
        .r   (mult_r)
    );

    // ==============================
    // Normalize into [0.5, 1)
    // ==============================
    assign lead_pos  = lead_one(b_in);
    assign shift     = 6'd63 - lead_pos;
    assign b_norm_in = {64'b0, b_in} << shift;

    always_ff @(posedge clk) begin
        if (start) begin
            a_norm <= {64'b0, a_in} << shift;
            b_norm <= b_norm_in;
            b_orig <= b_in;
        end
    end

    assign seed_x = SEED_BASE - mult_r;
    assign x_next = {62'b0, x} + mult_r;

    // Seed lands at step 2, then a new estimate every fourth step
    always_ff @(posedge clk) begin
        if (counter == STEP_SEED) begin
            x <= seed_x[65:0];
        end else if (counter[1:0] == 2'b10) begin
            x <= x_next[65:0];
        end
    end

    // ==============================
    // Multiply sequence
    // ==============================
    always_comb begin
        if (start) begin
            mult_a = SEED_SLOPE;
            mult_b = b_norm_in;
        end else if (counter == STEP_SEED) begin
            mult_a = b_norm[65:0];
            mult_b = seed_x;
        end else if (counter == STEP_DIVIDEND) begin
            mult_a = x_next[65:0];
            mult_b = a_norm;
        end else if (counter == STEP_REMUL) begin
            // 2q times b/2 keeps the signed operand positive
            mult_a = {1'b0, mult_r[127:64], 1'b0};
            mult_b = {1'b0, b_orig, 63'b0};
        end else if (counter[1:0] == 2'b10) begin
            mult_a = b_norm[65:0];
            mult_b = x_next;
        end else begin
            // Correction x * (1 - b*x)
            mult_a = x;
            mult_b = FIX_ONE - mult_r;
        end
    end

    assign last_step = do_rem ? DONE_REM : DONE_QUOT;

    always_ff @(posedge clk) begin
        if (rst) begin
            counter <= '0;
        end else if (start) begin
            counter <= 6'd1;
        end else if (counter == last_step) begin
            counter <= '0;
        end else if (counter != '0) begin
            counter <= counter + 6'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= (counter == last_step);
        end
    end

    always_ff @(posedge clk) begin
        if (counter == last_step) begin
            result <= do_rem ? mult_r[63:0] : mult_r[127:64];
        end
    end

    a_start_known: assert property (@(posedge clk) disable iff (rst)
        start |-> !$isunknown({a_in, b_in}));

    // Dispatcher must not restart a lane that is still iterating
    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        start |-> counter == '0);

endmodule

// File: design/div_dispatch.sv
`timescale 1ns/100ps
`include "div_params.svh"

module div_dispatch (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  div_pkg::div_req_t     req,
    input  logic [`DIV_LANES-1:0] lane_done,
    output logic                  ready,
    output logic [`DIV_LANES-1:0] start,
    output div_pkg::div_word_t    lane_a [`DIV_LANES],
    output div_pkg::div_word_t    lane_b [`DIV_LANES],
    output logic [`DIV_LANES-1:0] lane_do_rem,
    output div_pkg::div_ctx_t     ctx [`DIV_LANES]
);
    import div_pkg::*;

    localparam int SEL_W = (`DIV_LANES > 1) ? $clog2(`DIV_LANES) : 1;

    logic [`DIV_LANES-1:0] busy;
    logic [SEL_W-1:0]      free_lane;
    logic                  accept;
    logic                  b_zero;

    // Lowest numbered idle lane
    function automatic logic [SEL_W-1:0] lowest_idle(input logic [`DIV_LANES-1:0] busy_vec);
        logic [SEL_W-1:0] sel;
        sel = '0;
        for (int i = `DIV_LANES - 1; i >= 0; i--) begin
            if (!busy_vec[i]) begin
                sel = SEL_W'(i);
            end
        end
        return sel;
    endfunction

    assign ready     = ~&busy;
    assign accept    = req_valid && ready;
    assign free_lane = lowest_idle(busy);
    assign b_zero    = (req.b == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy        <= '0;
            start       <= '0;
            lane_do_rem <= '0;
        end else begin
            start <= '0;
            busy  <= busy & ~lane_done;
            if (accept) begin
                start[free_lane]       <= 1'b1;
                busy[free_lane]        <= 1'b1;
                lane_do_rem[free_lane] <= req.do_rem;
            end
        end
    end

    // Divisor 1 stands in for zero, collector patches the result
    always_ff @(posedge clk) begin
        if (accept) begin
            lane_a[free_lane] <= req.a;
            lane_b[free_lane] <= b_zero ? div_word_t'(1) : req.b;
            ctx[free_lane]    <= '{tag: req.tag, a: req.a, b_zero: b_zero, do_rem: req.do_rem};
        end
    end

    a_req_ready: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> ready);

endmodule

// File: design/div_collect.sv
`timescale 1ns/100ps
`include "div_params.svh"

module div_collect (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`DIV_LANES-1:0] lane_done,
    input  div_pkg::div_word_t    lane_result [`DIV_LANES],
    input  div_pkg::div_ctx_t     ctx [`DIV_LANES],
    output logic                  resp_valid,
    output div_pkg::div_resp_t    resp
);
    import div_pkg::*;

    localparam int PTR_W = (`DIV_QUEUE_DEPTH > 1) ? $clog2(`DIV_QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(`DIV_QUEUE_DEPTH + 1);

    div_resp_t        queue_mem [`DIV_QUEUE_DEPTH];
    div_resp_t        finished [`DIV_LANES];
    logic [PTR_W-1:0] slot [`DIV_LANES];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] push_cnt;
    logic             pop;

    // Circular pointer step, depth need not be a power of two
    function automatic logic [PTR_W-1:0] wrap_add(input logic [PTR_W-1:0] base, input int step);
        int sum;
        sum = int'(base) + step;
        if (sum >= `DIV_QUEUE_DEPTH) begin
            sum = sum - `DIV_QUEUE_DEPTH;
        end
        return PTR_W'(sum);
    endfunction

    // ==============================
    // Final result per lane
    // ==============================
    always_comb begin
        for (int i = 0; i < `DIV_LANES; i++) begin
            finished[i].tag     = ctx[i].tag;
            finished[i].by_zero = ctx[i].b_zero;
            if (ctx[i].b_zero) begin
                finished[i].result = ctx[i].do_rem ? ctx[i].a : '1;
            end else if (ctx[i].do_rem) begin
                // Lane hands back q*b
                finished[i].result = ctx[i].a - lane_result[i];
            end else begin
                finished[i].result = lane_result[i];
            end
        end
    end

    // Slots in lane order for simultaneous completions
    always_comb begin
        int n;
        n = 0;
        for (int i = 0; i < `DIV_LANES; i++) begin
            slot[i] = wrap_add(wr_ptr, n);
            if (lane_done[i]) begin
                n = n + 1;
            end
        end
        push_cnt = CNT_W'(n);
    end

    assign pop = (count != '0);

    always_ff @(posedge clk) begin
        for (int i = 0; i < `DIV_LANES; i++) begin
            if (lane_done[i]) begin
                queue_mem[slot[i]] <= finished[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            resp_valid <= 1'b0;
        end else begin
            wr_ptr     <= wrap_add(wr_ptr, int'(push_cnt));
            rd_ptr     <= pop ? wrap_add(rd_ptr, 1) : rd_ptr;
            count      <= count + push_cnt - CNT_W'(pop);
            resp_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            resp <= queue_mem[rd_ptr];
        end
    end

    // One slot per lane is enough only while lanes never outrun the drain
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        int'(count) + int'(push_cnt) - int'(pop) <= `DIV_QUEUE_DEPTH);

endmodule

// File: design/div_unit_top.sv
`timescale 1ns/100ps
`include "div_params.svh"

module div_unit_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid,
    input  div_pkg::div_req_t  req,
    output logic               ready,
    output logic               resp_valid,
    output div_pkg::div_resp_t resp
);
    import div_pkg::*;

    logic [`DIV_LANES-1:0] start;
    logic [`DIV_LANES-1:0] lane_done;
    logic [`DIV_LANES-1:0] lane_do_rem;
    div_word_t             lane_a [`DIV_LANES];
    div_word_t             lane_b [`DIV_LANES];
    div_word_t             lane_result [`DIV_LANES];
    div_ctx_t              ctx [`DIV_LANES];

    div_dispatch div_dispatch_inst (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req         (req),
        .lane_done   (lane_done),
        .ready       (ready),
        .start       (start),
        .lane_a      (lane_a),
        .lane_b      (lane_b),
        .lane_do_rem (lane_do_rem),
        .ctx         (ctx)
    );

    // ==============================
    // Divide lanes
    // ==============================
    for (genvar i = 0; i < `DIV_LANES; i++) begin : g_lane
        nr_divider nr_divider_inst (
            .clk    (clk),
            .rst    (rst),
            .start  (start[i]),
            .a_in   (lane_a[i]),
            .b_in   (lane_b[i]),
            .do_rem (lane_do_rem[i]),
            .done   (lane_done[i]),
            .result (lane_result[i])
        );
    end

    div_collect div_collect_inst (
        .clk         (clk),
        .rst         (rst),
        .lane_done   (lane_done),
        .lane_result (lane_result),
        .ctx         (ctx),
        .resp_valid  (resp_valid),
        .resp        (resp)
    );

endmodule

// File: test/div_unit_tb.sv
`timescale 1ns/100ps
`include "div_params.svh"

module div_unit_tb;
    import div_pkg::*;

    localparam int TAG_COUNT    = 1 << `DIV_TAG_W;
    localparam int RESET_CYCLES = 16;
    localparam int RANDOM_ROWS  = 24;

    logic      clk;
    logic      rst;
    logic      req_valid;
    div_req_t  req;
    logic      ready;
    logic      resp_valid;
    div_resp_t resp;

    // Stimulus table with one entry per row
    string     row_name [$];
    div_word_t row_a [$];
    div_word_t row_b [$];
    bit        row_rem [$];
    int        row_gap [$];

    // Expected results indexed by tag
    bit        pending [TAG_COUNT];
    div_word_t exp_val [TAG_COUNT];
    bit        exp_bz [TAG_COUNT];
    string     exp_name [TAG_COUNT];

    int issued_cnt      = 0;
    int returned_cnt    = 0;
    int value_errors    = 0;
    int protocol_errors = 0;
    int check_errors    = 0;
    int cycle_cnt       = 0;
    int timeout_limit   = 0;
    bit saw_ready_low   = 1'b0;

    div_unit_top div_unit_top_inst (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .ready      (ready),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    always #20 clk = ~clk;

    // Unsigned divide with the zero-divisor rule
    function automatic div_word_t expected_result(input div_word_t a, input div_word_t b,
                                                  input bit rem);
        if (b == '0) begin
            return rem ? a : '1;
        end
        return rem ? a % b : a / b;
    endfunction

    task automatic add_row(input string name, input div_word_t a, input div_word_t b,
                           input bit rem, input int gap);
        row_name.push_back(name);
        row_a.push_back(a);
        row_b.push_back(b);
        row_rem.push_back(rem);
        row_gap.push_back(gap);
    endtask

    // ==============================
    // Stimulus table
    // ==============================
    task automatic build_table();
        div_word_t a;
        div_word_t b;
        add_row("pow2_quot", 64'h1 << 40, 64'h1 << 8, 1'b0, 2);
        add_row("pow2_rem", (64'h1 << 40) + 64'd77, 64'h1 << 8, 1'b1, 2);
        add_row("equal_quot", 64'd12345, 64'd12345, 1'b0, 2);
        add_row("equal_rem", 64'd12345, 64'd12345, 1'b1, 2);
        add_row("small_quot", 64'd7, 64'd100, 1'b0, 2);
        add_row("small_rem", 64'd7, 64'd100, 1'b1, 2);
        add_row("ones_quot", '1, '1, 1'b0, 2);
        add_row("ones_by_3_rem", '1, 64'd3, 1'b1, 2);
        add_row("ones_by_1_quot", '1, 64'd1, 1'b0, 2);
        add_row("top_bit_quot", '1, 64'h8000_0000_0000_0000, 1'b0, 2);
        add_row("zero_div_quot", 64'd1234, '0, 1'b0, 2);
        add_row("zero_div_rem", 64'd1234, '0, 1'b1, 40);
        // Back-to-back burst into idle lanes with more rows than lanes
        add_row("burst_0", 64'hDEAD_BEEF_0000_1234, 64'd97, 1'b1, 0);
        add_row("burst_1", 64'hDEAD_BEEF_0000_1234, 64'd97, 1'b0, 0);
        add_row("burst_2", 64'hFFFF_0000_FFFF_0000, 64'h1_0001, 1'b0, 0);
        add_row("burst_3", 64'hFFFF_0000_FFFF_0000, 64'h1_0001, 1'b1, 0);
        add_row("burst_4", 64'd1000000007, '0, 1'b1, 0);
        add_row("burst_5", 64'h0123_4567_89AB_CDEF, 64'h0000_0001_0000_0003, 1'b0, 0);
        add_row("burst_6", 64'h0123_4567_89AB_CDEF, 64'h0000_0001_0000_0003, 1'b1, 0);
        add_row("burst_7", 64'd5, 64'd9, 1'b0, 3);
        for (int i = 0; i < RANDOM_ROWS; i++) begin
            a = {$urandom, $urandom};
            b = {$urandom, $urandom} >> ($urandom % 64);
            if ($urandom % 12 == 0) begin
                b = '0;
            end
            add_row($sformatf("rand_%0d", i), a, b, 1'($urandom % 2), int'($urandom % 4));
        end
    endtask

    task automatic check_idle_outputs(input string phase);
        assert (resp_valid === 1'b0 && ready === 1'b1) else begin
            check_errors++;
            $display("Outputs not idle %s: resp_valid=%b ready=%b", phase, resp_valid, ready);
        end
    endtask

    task automatic issue_row(input int idx);
        div_tag_t tag;
        tag = div_tag_t'(idx % TAG_COUNT);
        while (!ready) begin
            saw_ready_low = 1'b1;
            @(negedge clk);
        end
        req_valid = 1'b1;
        req = '{tag: tag, a: row_a[idx], b: row_b[idx], do_rem: row_rem[idx]};
        exp_val[tag]  = expected_result(row_a[idx], row_b[idx], row_rem[idx]);
        exp_bz[tag]   = (row_b[idx] == '0);
        exp_name[tag] = row_name[idx];
        pending[tag]  = 1'b1;
        issued_cnt++;
        @(negedge clk);
        req_valid = 1'b0;
        repeat (row_gap[idx]) @(negedge clk);
    endtask

    // ==============================
    // Response monitor
    // ==============================
    always @(negedge clk) begin
        if (!rst && resp_valid) begin
            assert (pending[resp.tag]) else begin
                protocol_errors++;
                $display("Response with tag %0d arrived but no such request was outstanding",
                         resp.tag);
            end
            if (pending[resp.tag]) begin
                assert (resp.result == exp_val[resp.tag]) else begin
                    value_errors++;
                    $display("FAILED %s: expected %h, actual %h", exp_name[resp.tag],
                             exp_val[resp.tag], resp.result);
                end
                assert (resp.by_zero == exp_bz[resp.tag]) else begin
                    value_errors++;
                    $display("FAILED %s by_zero: expected %b, actual %b", exp_name[resp.tag],
                             exp_bz[resp.tag], resp.by_zero);
                end
                pending[resp.tag] = 1'b0;
                returned_cnt++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
            $display("Timeout after %0d cycles, %0d of %0d responses received",
                     cycle_cnt, returned_cnt, issued_cnt);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        int total_errors;
        void'($urandom(32'h29858a70));
        clk       = 1'b0;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        build_table();
        timeout_limit = row_a.size() * 40 + 200;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_idle_outputs("during reset");
        end
        rst = 1'b0;
        @(negedge clk);
        check_idle_outputs("after reset");

        for (int i = 0; i < row_a.size(); i++) begin
            issue_row(i);
        end

        while (returned_cnt != issued_cnt) begin
            @(posedge clk);
        end
        // Quiet period where the monitor catches any stray response
        repeat (40) @(negedge clk);

        assert (saw_ready_low) else begin
            check_errors++;
            $display("ready never fell while all lanes were busy");
        end
        for (int t = 0; t < TAG_COUNT; t++) begin
            assert (!pending[t]) else begin
                check_errors++;
                $display("Tag %0d was issued but never returned", t);
            end
        end

        total_errors = value_errors + protocol_errors + check_errors;
        $display("Errors: %0d total, %0d value, %0d protocol, %0d other, %0d rows",
                 total_errors, value_errors, protocol_errors, check_errors, issued_cnt);
        if (total_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+common
common/div_pkg.sv
divider/recip_mult.sv
divider/nr_divider.sv
design/div_dispatch.sv
design/div_collect.sv
design/div_unit_top.sv
test/div_unit_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the divide unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module div_unit_tb \
    -Mdir obj_dir -o div_unit_sim > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/div_unit_sim > sim.log 2>&1; cat sim.log

grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0
